// ==== Bender.yml ====
package:
  name: lsu_bus_intf

sources:
  - include_dirs: [design]
    files:
      - design/lsu_pkt_pkg.sv
      - design/lsu_lane_pkg.sv
      - design/lsu_lane_split.sv
      - design/lsu_r_stage.sv
      - design/lsu_store_fwd.sv
      - design/lsu_bus_intf.sv
  - target: test
    include_dirs: [design]
    files:
      - tests/lsu_bus_intf_tb.sv

// ==== design/lsu_bus_intf.sv ====
`timescale 1ns/1ps
`include "lsu_consts.svh"

module lsu_bus_intf
  import lsu_pkt_pkg::*, lsu_lane_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  lsu_pkt_t               pkt_m,
  input  logic [`LSU_ADDR_W-1:0] addr_m,
  input  logic [`LSU_DATA_W-1:0] store_data_m,
  input  logic                   flush_m,
  output logic [`LSU_DATA_W-1:0] bus_read_data_m,
  output logic                   ld_full_hit_m,
  output logic                   busreq_r,
  output lsu_merge_t             merge_r
);

  // m side
  lsu_lanes_t             lanes_m;
  logic [`LSU_ADDR_W-1:0] end_addr_m;
  logic                   dual_m;

  // r side
  lsu_pkt_t               pkt_r;
  logic [`LSU_ADDR_W-1:0] addr_r;
  logic [`LSU_ADDR_W-1:0] end_addr_r;
  lsu_lanes_t             lanes_r;

  lsu_lane_split u_lane_split_m (
    .pkt      (pkt_m),
    .addr     (addr_m),
    .data     (store_data_m),
    .lanes    (lanes_m),
    .end_addr (end_addr_m),
    .dual     (dual_m)
  );

  lsu_r_stage u_r_stage (
    .clk        (clk),
    .rst_n      (rst_n),
    .pkt_m      (pkt_m),
    .addr_m     (addr_m),
    .end_addr_m (end_addr_m),
    .dual_m     (dual_m),
    .lanes_m    (lanes_m),
    .flush_m    (flush_m),
    .pkt_r      (pkt_r),
    .addr_r     (addr_r),
    .end_addr_r (end_addr_r),
    .lanes_r    (lanes_r),
    .busreq_r   (busreq_r),
    .merge_r    (merge_r)
  );

  lsu_store_fwd u_store_fwd (
    .pkt_m           (pkt_m),
    .addr_m          (addr_m),
    .end_addr_m      (end_addr_m),
    .lanes_m         (lanes_m),
    .pkt_r           (pkt_r),
    .addr_r          (addr_r),
    .end_addr_r      (end_addr_r),
    .lanes_r         (lanes_r),
    .bus_read_data_m (bus_read_data_m),
    .ld_full_hit_m   (ld_full_hit_m)
  );

endmodule

// ==== design/lsu_consts.svh ====
`ifndef LSU_CONSTS_SVH
`define LSU_CONSTS_SVH

// **************************************************
// geometry of the load/store pipe
// **************************************************

// byte address width
`define LSU_ADDR_W 32

// one word of data per lane
`define LSU_DATA_W 32

// bytes per word, so byte enables per lane
`define LSU_LANES 4

// width of one byte lane slice
`define LSU_BYTE_W 8

`endif

// ==== design/lsu_lane_pkg.sv ====
`include "lsu_consts.svh"

package lsu_lane_pkg;

  // **************************************************
  // two-lane byte view of a single access
  // **************************************************

  // lo lane holds the word at addr[31:2], hi lane the next word
  // an access that stays within one word leaves the hi lane empty
  typedef struct packed {
    logic [`LSU_LANES-1:0]  byteen_lo;
    logic [`LSU_LANES-1:0]  byteen_hi;
    logic [`LSU_DATA_W-1:0] data_lo;
    logic [`LSU_DATA_W-1:0] data_hi;
  } lsu_lanes_t;

  // merge verdict for the access sitting in r
  // a set bit means the r access cannot be coalesced with the m access
  typedef struct packed {
    logic no_word_merge;
    logic no_dword_merge;
  } lsu_merge_t;

endpackage

// ==== design/lsu_lane_split.sv ====
`timescale 1ns/1ps
`include "lsu_consts.svh"

module lsu_lane_split
  import lsu_pkt_pkg::*, lsu_lane_pkg::*;
(
  input  lsu_pkt_t               pkt,
  input  logic [`LSU_ADDR_W-1:0] addr,
  input  logic [`LSU_DATA_W-1:0] data,
  output lsu_lanes_t             lanes,
  output logic [`LSU_ADDR_W-1:0] end_addr,
  output logic                   dual
);

  logic [`LSU_LANES-1:0]    byte_mask;  // unshifted enables
  logic [1:0]               last_offs;  // offset of the last byte in the access
  logic [2*`LSU_LANES-1:0]  byteen_ext;
  logic [2*`LSU_DATA_W-1:0] data_ext;

  always_comb begin
    byte_mask = '0;
    last_offs = 2'd0;
    case (pkt.size)
      size_byte: begin
        byte_mask = 4'b0001;
        last_offs = 2'd0;
      end
      size_half: begin
        byte_mask = 4'b0011;
        last_offs = 2'd1;
      end
      size_word: begin
        byte_mask = 4'b1111;
        last_offs = 2'd3;
      end
      default: ;
    endcase
  end

  // spread over eight bytes so a misaligned access lands partly in the hi lane
  assign byteen_ext = {{`LSU_LANES{1'b0}}, byte_mask} << addr[1:0];
  assign data_ext   = {{`LSU_DATA_W{1'b0}}, data} << (addr[1:0] * `LSU_BYTE_W);

  assign end_addr = addr + {{(`LSU_ADDR_W-2){1'b0}}, last_offs};
  assign dual     = addr[2] ^ end_addr[2]; // access spans two words

  always_comb begin
    lanes.byteen_lo = byteen_ext[`LSU_LANES-1:0];
    lanes.byteen_hi = byteen_ext[2*`LSU_LANES-1:`LSU_LANES];
    lanes.data_lo   = data_ext[`LSU_DATA_W-1:0];
    lanes.data_hi   = data_ext[2*`LSU_DATA_W-1:`LSU_DATA_W];
  end

endmodule

// ==== design/lsu_pkt_pkg.sv ====
`include "lsu_consts.svh"

package lsu_pkt_pkg;

  // **************************************************
  // access packet as it moves from m to r
  // **************************************************

  // access size, double-word accesses are not carried by this pipe
  typedef enum logic [1:0] {
    size_byte = 2'b00,
    size_half = 2'b01,
    size_word = 2'b10
  } lsu_size_e;

  typedef enum logic {
    op_load  = 1'b0,
    op_store = 1'b1
  } lsu_op_e;

  // 7 bits, valid on top
  typedef struct packed {
    logic      valid;      // single-cycle strobe
    lsu_op_e   op;
    lsu_size_e size;
    logic      busreq;     // access goes out to the bus
    logic      sideeffect; // io-like target, never forwarded to
    logic      spare;      // reserved, driven 0
  } lsu_pkt_t;

endpackage

// ==== design/lsu_r_stage.sv ====
`timescale 1ns/1ps
`include "lsu_consts.svh"

module lsu_r_stage
  import lsu_pkt_pkg::*, lsu_lane_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  lsu_pkt_t               pkt_m,
  input  logic [`LSU_ADDR_W-1:0] addr_m,
  input  logic [`LSU_ADDR_W-1:0] end_addr_m,
  input  logic                   dual_m,
  input  lsu_lanes_t             lanes_m,
  input  logic                   flush_m,
  output lsu_pkt_t               pkt_r,
  output logic [`LSU_ADDR_W-1:0] addr_r,
  output logic [`LSU_ADDR_W-1:0] end_addr_r,
  output lsu_lanes_t             lanes_r,
  output logic                   busreq_r,
  output lsu_merge_t             merge_r
);

  logic dual_r;
  logic busreq_m;
  logic match_dword; // same double-word in r and m
  logic match_word;

  // **************************************************
  // r-stage registers
  // **************************************************

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pkt_r <= '0;
    end else begin
      pkt_r       <= pkt_m;
      pkt_r.valid <= pkt_m.valid & ~flush_m; // flushed access never reaches r
    end
  end

  // payload moves with the pipe on every clock
  always_ff @(posedge clk) begin
    addr_r     <= addr_m;
    end_addr_r <= end_addr_m;
    dual_r     <= dual_m;
    lanes_r    <= lanes_m;
  end

  assign busreq_r = pkt_r.valid & pkt_r.busreq;
  assign busreq_m = pkt_m.valid & pkt_m.busreq;

  // **************************************************
  // coalescing check of r against the younger m access
  // **************************************************

  assign match_dword = (addr_r[`LSU_ADDR_W-1:3] == addr_m[`LSU_ADDR_W-1:3]);
  assign match_word  = match_dword & (addr_r[2] == addr_m[2]);

  // a load behind the r access always closes the merge window
  always_comb begin
    merge_r.no_word_merge  = busreq_r & ~dual_r & busreq_m &
                             ((pkt_m.op == op_load) | ~match_word);
    merge_r.no_dword_merge = busreq_r & ~dual_r & busreq_m &
                             ((pkt_m.op == op_load) | ~match_dword);
  end

  // a live r access must carry a crossing flag that matches its own addresses
  a_dual_r: assert property (@(posedge clk) disable iff (!rst_n)
    pkt_r.valid |-> (dual_r == (addr_r[`LSU_ADDR_W-1:2] != end_addr_r[`LSU_ADDR_W-1:2])))
    else $error("r-stage crossing flag disagrees with its addresses");

endmodule

// ==== design/lsu_store_fwd.sv ====
`timescale 1ns/1ps
`include "lsu_consts.svh"

module lsu_store_fwd
  import lsu_pkt_pkg::*, lsu_lane_pkg::*;
(
  input  lsu_pkt_t               pkt_m,
  input  logic [`LSU_ADDR_W-1:0] addr_m,
  input  logic [`LSU_ADDR_W-1:0] end_addr_m,
  input  lsu_lanes_t             lanes_m,
  input  lsu_pkt_t               pkt_r,
  input  logic [`LSU_ADDR_W-1:0] addr_r,
  input  logic [`LSU_ADDR_W-1:0] end_addr_r,
  input  lsu_lanes_t             lanes_r,
  output logic [`LSU_DATA_W-1:0] bus_read_data_m,
  output logic                   ld_full_hit_m
);

  logic                     fwd_en;      // r holds a store that m may see
  // word hits, named <r lane>_<m lane>
  logic                     addr_hit_lo_lo;
  logic                     addr_hit_lo_hi;
  logic                     addr_hit_hi_lo;
  logic                     addr_hit_hi_hi;
  logic [`LSU_LANES-1:0]    byte_hit_lo_lo;
  logic [`LSU_LANES-1:0]    byte_hit_lo_hi;
  logic [`LSU_LANES-1:0]    byte_hit_hi_lo;
  logic [`LSU_LANES-1:0]    byte_hit_hi_hi;
  logic [`LSU_LANES-1:0]    byte_hit_lo; // per m lane, any r lane
  logic [`LSU_LANES-1:0]    byte_hit_hi;
  logic [`LSU_DATA_W-1:0]   fwd_data_lo;
  logic [`LSU_DATA_W-1:0]   fwd_data_hi;
  logic [2*`LSU_DATA_W-1:0] fwd_data_ext;
  logic                     full_hit_lo;
  logic                     full_hit_hi;

  // **************************************************
  // word address compare, start and end of both accesses
  // **************************************************

  assign fwd_en = pkt_r.valid & (pkt_r.op == op_store) &
                  pkt_m.valid & pkt_m.busreq & ~pkt_m.sideeffect;

  assign addr_hit_lo_lo = fwd_en &
                          (addr_m[`LSU_ADDR_W-1:2] == addr_r[`LSU_ADDR_W-1:2]);
  assign addr_hit_lo_hi = fwd_en &
                          (end_addr_m[`LSU_ADDR_W-1:2] == addr_r[`LSU_ADDR_W-1:2]);
  assign addr_hit_hi_lo = fwd_en &
                          (addr_m[`LSU_ADDR_W-1:2] == end_addr_r[`LSU_ADDR_W-1:2]);
  assign addr_hit_hi_hi = fwd_en &
                          (end_addr_m[`LSU_ADDR_W-1:2] == end_addr_r[`LSU_ADDR_W-1:2]);

  // **************************************************
  // per-byte hit and data select
  // **************************************************

  for (genvar i = 0; i < `LSU_LANES; i++) begin : g_byte
    assign byte_hit_lo_lo[i] = addr_hit_lo_lo & lanes_r.byteen_lo[i] & lanes_m.byteen_lo[i];
    assign byte_hit_lo_hi[i] = addr_hit_lo_hi & lanes_r.byteen_lo[i] & lanes_m.byteen_hi[i];
    assign byte_hit_hi_lo[i] = addr_hit_hi_lo & lanes_r.byteen_hi[i] & lanes_m.byteen_lo[i];
    assign byte_hit_hi_hi[i] = addr_hit_hi_hi & lanes_r.byteen_hi[i] & lanes_m.byteen_hi[i];

    assign byte_hit_lo[i] = byte_hit_lo_lo[i] | byte_hit_hi_lo[i];
    assign byte_hit_hi[i] = byte_hit_lo_hi[i] | byte_hit_hi_hi[i];

    // uncovered bytes read as zero
    assign fwd_data_lo[i*`LSU_BYTE_W +: `LSU_BYTE_W] =
      ({`LSU_BYTE_W{byte_hit_lo_lo[i]}} & lanes_r.data_lo[i*`LSU_BYTE_W +: `LSU_BYTE_W]) |
      ({`LSU_BYTE_W{byte_hit_hi_lo[i]}} & lanes_r.data_hi[i*`LSU_BYTE_W +: `LSU_BYTE_W]);
    assign fwd_data_hi[i*`LSU_BYTE_W +: `LSU_BYTE_W] =
      ({`LSU_BYTE_W{byte_hit_lo_hi[i]}} & lanes_r.data_lo[i*`LSU_BYTE_W +: `LSU_BYTE_W]) |
      ({`LSU_BYTE_W{byte_hit_hi_hi[i]}} & lanes_r.data_hi[i*`LSU_BYTE_W +: `LSU_BYTE_W]);
  end

  // **************************************************
  // full hit and result alignment
  // **************************************************

  always_comb begin
    full_hit_lo = 1'b1;
    full_hit_hi = 1'b1;
    for (int i = 0; i < `LSU_LANES; i++) begin
      full_hit_lo &= byte_hit_lo[i] | ~lanes_m.byteen_lo[i];
      full_hit_hi &= byte_hit_hi[i] | ~lanes_m.byteen_hi[i];
    end
  end

  assign ld_full_hit_m = full_hit_lo & full_hit_hi & pkt_m.valid & pkt_m.busreq &
                         (pkt_m.op == op_load) & ~pkt_m.sideeffect;

  // back to a right-justified load result
  assign fwd_data_ext    = {fwd_data_hi, fwd_data_lo} >> (addr_m[1:0] * `LSU_BYTE_W);
  assign bus_read_data_m = fwd_data_ext[`LSU_DATA_W-1:0];

  // a full hit is only ever a load fed by a live store in r
  always_comb begin
    a_full_hit_src: assert final (!ld_full_hit_m ||
      ((pkt_m.op == op_load) && pkt_r.valid && (pkt_r.op == op_store)))
      else $error("full hit without a load in m and a store in r");
  end

endmodule

// ==== sim.f ====
+incdir+design
design/lsu_pkt_pkg.sv
design/lsu_lane_pkg.sv
design/lsu_lane_split.sv
design/lsu_r_stage.sv
design/lsu_store_fwd.sv
design/lsu_bus_intf.sv
tests/lsu_bus_intf_tb.sv

// ==== tests/lsu_bus_intf_tb.sv ====
`timescale 1ns/1ps
`include "lsu_consts.svh"

module lsu_bus_intf_tb
  import lsu_pkt_pkg::*, lsu_lane_pkg::*;
();

  localparam int N_DIRECTED = 10;
  localparam int N_RANDOM   = 8;
  localparam int N_PAIRS    = N_DIRECTED + N_RANDOM;
  localparam int CLK_PERIOD = 8;

  typedef struct packed {
    lsu_pkt_t               pkt;
    logic [`LSU_ADDR_W-1:0] addr;
    logic [`LSU_DATA_W-1:0] data;
    logic                   flush;
  } acc_t;

  typedef struct packed {
    logic [`LSU_DATA_W-1:0] rdata;
    logic                   full_hit;
    logic                   busreq_r;
    lsu_merge_t             merge;
  } expect_t;

  logic                   clk;
  logic                   rst_n;
  lsu_pkt_t               pkt_m;
  logic [`LSU_ADDR_W-1:0] addr_m;
  logic [`LSU_DATA_W-1:0] store_data_m;
  logic                   flush_m;
  logic [`LSU_DATA_W-1:0] bus_read_data_m;
  logic                   ld_full_hit_m;
  logic                   busreq_r;
  lsu_merge_t             merge_r;

  string   names [N_PAIRS];
  acc_t    first [N_PAIRS];  // goes to r
  acc_t    second [N_PAIRS]; // checked while in m
  expect_t expected [N_PAIRS];
  int      n_filled;
  int      errors;
  integer  seed;

  lsu_bus_intf UUT (
    .clk             (clk),
    .rst_n           (rst_n),
    .pkt_m           (pkt_m),
    .addr_m          (addr_m),
    .store_data_m    (store_data_m),
    .flush_m         (flush_m),
    .bus_read_data_m (bus_read_data_m),
    .ld_full_hit_m   (ld_full_hit_m),
    .busreq_r        (busreq_r),
    .merge_r         (merge_r)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // **************************************************
  // reference model, one byte address at a time
  // **************************************************

  function automatic int size_bytes(lsu_size_e size);
    case (size)
      size_byte: return 1;
      size_half: return 2;
      default:   return 4;
    endcase
  endfunction

  function automatic acc_t access(lsu_op_e op, lsu_size_e size, logic [31:0] addr,
                                  logic [31:0] data);
    acc_t a;
    a            = '0;
    a.pkt.valid  = 1'b1;
    a.pkt.op     = op;
    a.pkt.size   = size;
    a.pkt.busreq = 1'b1;
    a.addr       = addr;
    a.data       = data;
    return a;
  endfunction

  function automatic expect_t predict(acc_t r, acc_t m);
    expect_t e;
    int      rn;
    int      mn;
    logic    r_live;
    logic    m_bus;
    logic    m_load;
    logic    fwd;
    logic    covered;
    logic    dual_r;
    e      = '0;
    rn     = size_bytes(r.pkt.size);
    mn     = size_bytes(m.pkt.size);
    r_live = r.pkt.valid & ~r.flush;
    m_bus  = m.pkt.valid & m.pkt.busreq;
    m_load = (m.pkt.op == op_load);
    fwd    = r_live & (r.pkt.op == op_store) & m_bus & ~m.pkt.sideeffect;
    e.full_hit = m_bus & m_load & ~m.pkt.sideeffect;
    for (int k = 0; k < mn; k++) begin
      covered = 1'b0;
      for (int j = 0; j < rn; j++) begin
        if (fwd && (r.addr + j == m.addr + k)) begin // same byte in memory
          covered = 1'b1;
          e.rdata[8*k +: 8] = r.data[8*j +: 8];
        end
      end
      if (!covered)
        e.full_hit = 1'b0;
    end
    dual_r     = ((r.addr + rn - 1) >> 2) != (r.addr >> 2);
    e.busreq_r = r_live & r.pkt.busreq;
    e.merge.no_word_merge  = e.busreq_r & ~dual_r & m_bus &
                             (m_load | (r.addr[31:2] != m.addr[31:2]));
    e.merge.no_dword_merge = e.busreq_r & ~dual_r & m_bus &
                             (m_load | (r.addr[31:3] != m.addr[31:3]));
    return e;
  endfunction

  task automatic add_pair(string name, acc_t a0, acc_t a1);
    names[n_filled]    = name;
    first[n_filled]    = a0;
    second[n_filled]   = a1;
    expected[n_filled] = predict(a0, a1);
    n_filled++;
  endtask

  task automatic drive(acc_t a);
    pkt_m        <= a.pkt;
    addr_m       <= a.addr;
    store_data_m <= a.data;
    flush_m      <= a.flush;
  endtask

  task automatic check_pair(int i);
    assert (bus_read_data_m === expected[i].rdata)
      else begin
        errors++;
        $display("** Error: %s read data: expected %h, actual %h",
                 names[i], expected[i].rdata, bus_read_data_m);
      end
    assert (ld_full_hit_m === expected[i].full_hit)
      else begin
        errors++;
        $display("** Error: %s full hit: expected %b, actual %b",
                 names[i], expected[i].full_hit, ld_full_hit_m);
      end
    assert ({busreq_r, merge_r} === {expected[i].busreq_r, expected[i].merge})
      else begin
        errors++;
        $display("** Error: %s busreq_r/merge: expected %b, actual %b",
                 names[i], {expected[i].busreq_r, expected[i].merge}, {busreq_r, merge_r});
      end
  endtask

  // **************************************************
  // stimulus table and run
  // **************************************************

  initial begin
    acc_t      a0;
    acc_t      a1;
    lsu_size_e sz0;
    lsu_size_e sz1;
    clk          = 1'b0;
    rst_n        = 1'b0;
    pkt_m        = '0;
    addr_m       = '0;
    store_data_m = '0;
    flush_m      = 1'b0;
    errors       = 0;
    n_filled     = 0;
    seed         = 22859;

    add_pair("idle after reset", '0, '0);
    add_pair("word store to word load", access(op_store, size_word, 32'h100, 32'hdeadbeef),
             access(op_load, size_word, 32'h100, '0));
    add_pair("word store to byte load", access(op_store, size_word, 32'h100, 32'hdeadbeef),
             access(op_load, size_byte, 32'h102, '0));
    add_pair("half store to word load", access(op_store, size_half, 32'h104, 32'h5a5a1234),
             access(op_load, size_word, 32'h104, '0));
    add_pair("crossing store, hi lane", access(op_store, size_word, 32'h10e, 32'ha1b2c3d4),
             access(op_load, size_word, 32'h110, '0));
    a0 = access(op_store, size_word, 32'h100, 32'h0badf00d);
    a0.flush = 1'b1; // killed in m
    add_pair("flushed store", a0, access(op_load, size_word, 32'h100, '0));
    a1 = access(op_load, size_word, 32'h100, '0);
    a1.pkt.sideeffect = 1'b1;
    add_pair("sideeffect load", access(op_store, size_word, 32'h100, 32'h0badf00d), a1);
    add_pair("store after store, same word", access(op_store, size_word, 32'h100, 32'h11223344),
             access(op_store, size_word, 32'h100, 32'h55667788));
    add_pair("store after store, other word", access(op_store, size_word, 32'h100, 32'h11223344),
             access(op_store, size_word, 32'h104, 32'h55667788));
    add_pair("load after store", access(op_store, size_word, 32'h100, 32'h11223344),
             access(op_load, size_word, 32'h104, '0));

    // random offsets within the double-word at 0x200
    for (int i = 0; i < N_RANDOM; i++) begin
      sz0 = lsu_size_e'($unsigned($random(seed)) % 3);
      sz1 = lsu_size_e'($unsigned($random(seed)) % 3);
      a0  = access(op_store, sz0, 32'h200 + ($unsigned($random(seed)) % 8), $random(seed));
      a1  = access(op_load, sz1, 32'h200 + ($unsigned($random(seed)) % 8), '0);
      add_pair($sformatf("random pair %0d", i), a0, a1);
    end

    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    for (int i = 0; i < N_PAIRS; i++) begin
      @(posedge clk);
      drive(first[i]);
      @(posedge clk);
      drive(second[i]);
      @(negedge clk); // outputs settled, first access now in r
      check_pair(i);
    end

    $display("errors: %0d", errors);
    if (errors == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

  initial begin
    #((2 * N_PAIRS + 20) * CLK_PERIOD * 2);
    $display("watchdog expired before the test table was done");
    $display("FAIL: see errors above");
    $finish;
  end

endmodule
